// File: sim.f
+incdir+.
icache_pkg.sv
icache_array_if.sv
icache_sram.sv
icache_ways.sv
icache_replace.sv
icache_ctrl.sv
icache_top.sv
icache_tb_clk.sv
icache_asserts.sv
icache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module icache_tb -f sim.f -o icache_sim

./obj_dir/icache_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -qx "all tests passed" sim.log; then
  exit 0
fi
exit 1

// File: icache_tb.sv
// instruction cache testbench with line memory model, phased fetch stimulus and watchdog
`include "icache_params.svh"

module icache_tb import icache_pkg::*; ();

  localparam int unsigned NUM_REQS        = 78;
  // forty cycles per request, plus three full set walks
  localparam int unsigned WATCHDOG_CYCLES = 40 * NUM_REQS + 3 * `ICACHE_SETS + 64;

  logic  clk;
  logic  rst_n;
  logic  flush;
  logic  en;
  logic  busy;
  logic  miss;
  logic  fetch_req;
  addr_t fetch_addr;
  logic  fetch_ready;
  logic  fetch_valid;
  word_t fetch_data;
  addr_t fetch_raddr;
  logic  mem_req;
  logic  mem_ack;
  addr_t mem_addr;
  logic  mem_nc;
  logic  mem_rtrn_vld;
  line_t mem_rtrn_data;
  // phase flags seen by the bound checker
  logic  quiet_q;
  logic  warm_q;
  logic  cold_q;
  logic  dis_q;
  int    seed;
  int    issued = 0;
  int    returned = 0;
  addr_t warm_addr [8];
  addr_t fetch_q [$];

  icache_tb_clk #(.PERIOD(100), .RESET_CYCLES(16)) i_clk (.clk_o(clk), .rst_no(rst_n));

  icache_top DUT (
    .clk_i (clk), .rst_ni (rst_n), .flush_i (flush), .en_i (en), .busy_o (busy),
    .miss_o (miss), .fetch_req_i (fetch_req), .fetch_addr_i (fetch_addr),
    .fetch_ready_o (fetch_ready), .fetch_valid_o (fetch_valid), .fetch_data_o (fetch_data),
    .fetch_addr_o (fetch_raddr), .mem_req_o (mem_req), .mem_ack_i (mem_ack),
    .mem_addr_o (mem_addr), .mem_nc_o (mem_nc), .mem_rtrn_vld_i (mem_rtrn_vld),
    .mem_rtrn_data_i (mem_rtrn_data)
  );

  bind icache_top icache_asserts i_asserts (
    .clk_i (clk_i), .rst_ni (rst_ni), .fetch_req_i (fetch_req_i),
    .fetch_addr_i (fetch_addr_i), .fetch_ready_i (fetch_ready_o),
    .fetch_valid_i (fetch_valid_o), .fetch_data_i (fetch_data_o), .rsp_addr_i (fetch_addr_o),
    .busy_i (busy_o), .miss_i (miss_o), .flush_i (flush_i), .mem_req_i (mem_req_o),
    .mem_ack_i (mem_ack_i), .mem_addr_i (mem_addr_o), .mem_nc_i (mem_nc_o),
    .quiet_i (icache_tb.quiet_q), .warm_i (icache_tb.warm_q), .cold_i (icache_tb.cold_q),
    .dis_i (icache_tb.dis_q)
  );

  ////////////////////
  // memory model
  ////////////////////

  function automatic line_t line_contents(input addr_t base);
    line_t l;
    for (int w = 0; w < LINE_W / 32; w++) begin
      l[w*32 +: 32] = (base + addr_t'(w * 4)) ^ 32'hc0de0000;
    end
    return l;
  endfunction

  // one ack and one return pulse per request, random gaps
  initial begin : memory_model
    addr_t line_addr;
    int    ack_dly;
    int    rtrn_dly;
    seed          = 32'hdebafabe;
    mem_ack       = 1'b0;
    mem_rtrn_vld  = 1'b0;
    mem_rtrn_data = '0;
    forever begin
      @(negedge clk);
      if (mem_req) begin
        line_addr = mem_addr;
        ack_dly   = int'($unsigned($random(seed)) % 4);
        rtrn_dly  = 1 + int'($unsigned($random(seed)) % 5);
        repeat (ack_dly) @(posedge clk);
        @(posedge clk);
        mem_ack <= 1'b1;
        @(posedge clk);
        mem_ack <= 1'b0;
        repeat (rtrn_dly - 1) @(posedge clk);
        mem_rtrn_vld  <= 1'b1;
        mem_rtrn_data <= line_contents(line_addr);
        @(posedge clk);
        mem_rtrn_vld  <= 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && fetch_valid) begin
      returned++;
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  // request stays up and moves on at each accept, then waits for all data
  task automatic issue_fetches();
    int   idx;
    logic acc;
    idx = 0;
    @(posedge clk);
    fetch_req  <= 1'b1;
    fetch_addr <= fetch_q[0];
    while (idx < fetch_q.size()) begin
      @(negedge clk);
      acc = fetch_ready;
      @(posedge clk);
      if (acc) begin
        idx++;
        issued++;
        if (idx < fetch_q.size()) begin
          fetch_addr <= fetch_q[idx];
        end else begin
          fetch_req <= 1'b0;
        end
      end
    end
    while (returned != issued) @(posedge clk);
  endtask

  task automatic queue_warm_lines();
    fetch_q.delete();
    foreach (warm_addr[i]) begin
      fetch_q.push_back(warm_addr[i]);
    end
  endtask

  task automatic report_counts();
    $display("errors %0d in assertions, fetches issued %0d, returned %0d",
             DUT.i_asserts.fail_cnt, issued, returned);
  endtask

  initial begin : stimulus
    fetch_req  = 1'b0;
    fetch_addr = '0;
    flush      = 1'b0;
    en         = 1'b0;
    quiet_q    = 1'b1;
    warm_q     = 1'b0;
    cold_q     = 1'b0;
    dis_q      = 1'b0;
    // eight lines in sets 0 to 7, varied word offsets
    for (int i = 0; i < 8; i++) begin
      warm_addr[i] = 32'h0001_0000 + addr_t'(i * 16 + (i % 4) * 4);
    end
    wait (rst_n);
    repeat (10) @(posedge clk);

    // enabling walks the sets first, then a filling pass and a hit pass
    quiet_q <= 1'b0;
    en      <= 1'b1;
    queue_warm_lines();
    issue_fetches();
    warm_q <= 1'b1;
    issue_fetches();
    warm_q <= 1'b0;

    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    while (busy) @(negedge clk);
    @(posedge clk);
    cold_q <= 1'b1;
    issue_fetches();
    cold_q <= 1'b0;

    // disabled, each address twice
    en <= 1'b0;
    repeat (2) @(posedge clk);
    dis_q <= 1'b1;
    fetch_q.delete();
    for (int i = 0; i < 3; i++) begin
      fetch_q.push_back(warm_addr[i * 3]);
      fetch_q.push_back(warm_addr[i * 3]);
    end
    issue_fetches();
    dis_q <= 1'b0;

    // 24 lines over sets 2 and 9, forward then backward
    en <= 1'b1;
    fetch_q.delete();
    for (int i = 0; i < 24; i++) begin
      fetch_q.push_back(32'h0040_0000 + addr_t'((i / 2) * 256
                        + ((i % 2 != 0) ? 9 * 16 : 2 * 16) + (i % 4) * 4));
    end
    for (int i = 23; i >= 0; i--) begin
      fetch_q.push_back(fetch_q[i]);
    end
    issue_fetches();

    repeat (4) @(posedge clk);
    report_counts();
    if (DUT.i_asserts.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout, the fetch sequence did not finish in %0d cycles", WATCHDOG_CYCLES);
    report_counts();
    $display("tests failed");
    $finish;
  end

endmodule

// File: icache_asserts.sv
// bound checker with concurrent assertions on fetch data, memory requests and test phases
module icache_asserts import icache_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  fetch_req_i,
  input addr_t fetch_addr_i,
  input logic  fetch_ready_i,
  input logic  fetch_valid_i,
  input word_t fetch_data_i,
  // address that belongs to the returned word
  input addr_t rsp_addr_i,
  input logic  busy_i,
  input logic  miss_i,
  input logic  flush_i,
  input logic  mem_req_i,
  input logic  mem_ack_i,
  input addr_t mem_addr_i,
  input logic  mem_nc_i,
  // phase flags from the testbench top
  input logic  quiet_i,
  input logic  warm_i,
  input logic  cold_i,
  input logic  dis_i
);

  addr_t       req_addr_q;
  int unsigned quiet_errs = 0;
  int unsigned data_errs = 0;
  int unsigned rsp_addr_errs = 0;
  int unsigned mem_addr_errs = 0;
  int unsigned flush_errs = 0;
  int unsigned warm_errs = 0;
  int unsigned cold_req_errs = 0;
  int unsigned cold_miss_errs = 0;
  int unsigned dis_req_errs = 0;
  int unsigned dis_miss_errs = 0;
  int unsigned fail_cnt;

  // backing memory holds each word's own byte address xor a fixed pattern
  function automatic word_t memory_word(input addr_t a);
    return word_t'({a[ADDR_W-1:2], 2'b00}) ^ 32'hc0de0000;
  endfunction

  function automatic addr_t word_base(input addr_t a);
    return {a[ADDR_W-1:2], 2'b00};
  endfunction

  function automatic addr_t line_base(input addr_t a);
    return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  endfunction

  // request being served, taken from the driven fetch address
  always_ff @(posedge clk_i) begin
    if (fetch_req_i && fetch_ready_i) begin
      req_addr_q <= fetch_addr_i;
    end
  end

  assign fail_cnt = quiet_errs + data_errs + rsp_addr_errs + mem_addr_errs + flush_errs
                  + warm_errs + cold_req_errs + cold_miss_errs + dis_req_errs
                  + dis_miss_errs;

  ////////////////////
  // all phases
  ////////////////////

  a_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
      quiet_i |-> !fetch_valid_i && !mem_req_i && !miss_i && !busy_i) else begin
    $error("cache outputs went active before the first request or flush");
    quiet_errs++;
  end

  a_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fetch_valid_i |-> fetch_data_i == memory_word(rsp_addr_i)) else begin
    $error("error fetch_data_o %h expected %h", $sampled(fetch_data_i),
           memory_word($sampled(rsp_addr_i)));
    data_errs++;
  end

  // returned word belongs to the accepted request
  a_rsp_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fetch_valid_i |-> rsp_addr_i == word_base(req_addr_q)) else begin
    $error("error fetch_addr_o %h expected %h", $sampled(rsp_addr_i),
           word_base($sampled(req_addr_q)));
    rsp_addr_errs++;
  end

  // refills fetch the whole line of the current request
  a_mem_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_req_i |-> mem_addr_i == line_base(req_addr_q)) else begin
    $error("error mem_addr_o %h expected %h", $sampled(mem_addr_i),
           line_base($sampled(req_addr_q)));
    mem_addr_errs++;
  end

  a_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
      flush_i && !busy_i |=> busy_i) else begin
    $error("busy did not rise after a flush pulse in idle");
    flush_errs++;
  end

  ////////////////////
  // phase rules
  ////////////////////

  // warm lines hit in one cycle without touching memory, ready for the next fetch
  a_warm: assert property (@(posedge clk_i) disable iff (!rst_ni)
      warm_i && fetch_req_i && fetch_ready_i
      |=> fetch_valid_i && fetch_ready_i && !mem_req_i && !miss_i) else begin
    $error("warm fetch was not a one cycle hit ready for the next request");
    warm_errs++;
  end

  a_cold_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cold_i && fetch_req_i && fetch_ready_i |=> mem_req_i && !mem_nc_i) else begin
    $error("flushed line did not start a cacheable refill");
    cold_req_errs++;
  end

  a_cold_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cold_i && mem_req_i && mem_ack_i |-> miss_i) else begin
    $error("miss pulse missing on an acknowledged refill after flush");
    cold_miss_errs++;
  end

  a_dis_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      dis_i && fetch_req_i && fetch_ready_i |=> mem_req_i && mem_nc_i) else begin
    $error("disabled fetch did not go to memory as non-cacheable");
    dis_req_errs++;
  end

  a_dis_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
      dis_i |-> !miss_i) else begin
    $error("miss pulse seen while the cache is disabled");
    dis_miss_errs++;
  end

endmodule

// File: icache_tb_clk.sv
// testbench clock and reset source for the instruction cache
module icache_tb_clk #(
  parameter int unsigned PERIOD       = 100,
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // reset released on a rising edge after the hold time
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: icache_top.sv
// set associative read-only instruction cache with a line refill port
module icache_top import icache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  // control
  input  logic  flush_i,
  input  logic  en_i,
  output logic  busy_o,
  output logic  miss_o,
  // fetch side
  input  logic  fetch_req_i,
  input  addr_t fetch_addr_i,
  output logic  fetch_ready_o,
  output logic  fetch_valid_o,
  output word_t fetch_data_o,
  output addr_t fetch_addr_o,
  // memory side
  output logic  mem_req_o,
  input  logic  mem_ack_i,
  output addr_t mem_addr_o,
  output logic  mem_nc_o,
  input  logic  mem_rtrn_vld_i,
  input  line_t mem_rtrn_data_i
);

  way_oh_t repl_way_oh;
  logic    refill_done;

  icache_array_if arr_if ();

  icache_ctrl i_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .en_i            (en_i),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_data_o    (fetch_data_o),
    .fetch_addr_o    (fetch_addr_o),
    .busy_o          (busy_o),
    .miss_o          (miss_o),
    .mem_req_o       (mem_req_o),
    .mem_ack_i       (mem_ack_i),
    .mem_addr_o      (mem_addr_o),
    .mem_nc_o        (mem_nc_o),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .repl_way_oh_i   (repl_way_oh),
    .refill_done_o   (refill_done),
    .ctl_if          (arr_if.ctrl)
  );

  // way state comes straight from the lookup results
  icache_replace i_replace (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .refill_done_i (refill_done),
    .all_valid_i   (arr_if.all_valid),
    .inv_way_i     (arr_if.inv_way),
    .repl_way_oh_o (repl_way_oh)
  );

  icache_ways i_ways (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .arr_if (arr_if.arr)
  );

endmodule

// File: icache_ctrl.sv
// instruction cache controller with fetch fsm, flush walker and refill requests
module icache_ctrl import icache_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    flush_i,
  input  logic    en_i,
  input  logic    fetch_req_i,
  input  addr_t   fetch_addr_i,
  output logic    fetch_ready_o,
  output logic    fetch_valid_o,
  output word_t   fetch_data_o,
  output addr_t   fetch_addr_o,
  output logic    busy_o,
  output logic    miss_o,
  output logic    mem_req_o,
  input  logic    mem_ack_i,
  output addr_t   mem_addr_o,
  output logic    mem_nc_o,
  input  logic    mem_rtrn_vld_i,
  input  line_t   mem_rtrn_data_i,
  input  way_oh_t repl_way_oh_i,
  output logic    refill_done_o,
  icache_array_if.ctrl ctl_if
);

  state_e  state_d, state_q;
  logic    cache_en_d, cache_en_q;
  // lookup issued with the cache enabled, also marks the fetch cacheable
  logic    cmp_en_d, cmp_en_q;
  logic    flush_d, flush_q;
  index_t  flush_cnt_d, flush_cnt_q;
  logic    flush_done;
  addr_t   addr_q;
  offset_t offset_q;
  logic    accept;
  logic    lookup_hit;
  logic    line_write;
  logic    enable_flush;
  logic    ready_ok;
  word_t   refill_word;

  ////////////////////
  // address handling
  ////////////////////

  assign accept       = fetch_req_i & fetch_ready_o;
  assign offset_q     = addr_q[OFFSET_W-1:0];
  assign fetch_addr_o = addr_q;
  // refills are always whole lines
  assign mem_addr_o   = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign mem_nc_o     = ~cmp_en_q;
  assign refill_word  = mem_rtrn_data_i[{offset_q, 3'b000} +: FETCH_W];
  assign fetch_data_o = (state_q == READ) ? ctl_if.hit_data : refill_word;

  // fetches are word aligned
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= {fetch_addr_i[ADDR_W-1:2], 2'b00};
    end
  end

  ////////////////////
  // fetch fsm
  ////////////////////

  assign busy_o       = (state_q != IDLE);
  assign lookup_hit   = cmp_en_q & (|ctl_if.hit);
  // switching on from disabled clears the arrays first
  assign enable_flush = en_i & ~cache_en_q;
  // returns share no cycle with a new lookup
  assign ready_ok     = ~flush_d & ~enable_flush & ~mem_rtrn_vld_i;
  assign cmp_en_d     = accept ? cache_en_q : cmp_en_q;

  always_comb begin
    state_d       = state_q;
    // disabling takes effect at once
    cache_en_d    = cache_en_q & en_i;
    flush_d       = flush_q | flush_i;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;
    line_write    = 1'b0;
    unique case (state_q)
      FLUSH: begin
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = flush_i;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        if (flush_d || enable_flush) begin
          state_d = FLUSH;
        end else begin
          fetch_ready_o = ready_ok;
          if (fetch_req_i && ready_ok) begin
            state_d = READ;
          end
        end
      end
      READ: begin
        if (lookup_hit) begin
          fetch_valid_o = 1'b1;
          fetch_ready_o = ready_ok;
          // back to back lookups while hits continue
          if (flush_d) begin
            state_d = FLUSH;
          end else if (fetch_req_i && ready_ok) begin
            state_d = READ;
          end else begin
            state_d = IDLE;
          end
        end else begin
          // miss or disabled cache, hold the request until acked
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = cmp_en_q;
            state_d = MISS;
          end
        end
      end
      MISS: begin
        if (mem_rtrn_vld_i) begin
          if (flush_d) begin
            // line is dropped, the flush clears everything anyway
            state_d = FLUSH;
          end else begin
            fetch_valid_o = 1'b1;
            line_write    = cmp_en_q;
            state_d       = IDLE;
          end
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////
  // flush walker
  ////////////////////

  assign flush_done  = (flush_cnt_q == index_t'(NUM_SETS - 1));
  assign flush_cnt_d = (state_q != FLUSH) ? flush_cnt_q :
                       flush_done         ? '0          :
                                            flush_cnt_q + 1'b1;

  ////////////////////
  // array requests
  ////////////////////

  assign ctl_if.rd_en     = accept & cache_en_q;
  assign ctl_if.wr_en     = line_write;
  assign ctl_if.vld_clr   = (state_q == FLUSH);
  assign ctl_if.wr_way_oh = repl_way_oh_i;
  assign ctl_if.wr_line   = mem_rtrn_data_i;
  assign ctl_if.offset    = {fetch_addr_i[OFFSET_W-1:2], 2'b00};
  // lookups use the incoming address, refills the latched one
  assign ctl_if.wr_tag    = accept ? fetch_addr_i[ADDR_W-1 -: TAG_W]
                                   : addr_q[ADDR_W-1 -: TAG_W];
  assign ctl_if.index     = (state_q == FLUSH) ? flush_cnt_q                    :
                            accept             ? fetch_addr_i[OFFSET_W +: INDEX_W] :
                                                 addr_q[OFFSET_W +: INDEX_W];
  assign refill_done_o    = line_write;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      cache_en_q  <= 1'b0;
      cmp_en_q    <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      cmp_en_q    <= cmp_en_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

endmodule

// File: icache_replace.sv
// refill way choice, first free way or a pseudo random way from an 8-bit lfsr
module icache_replace import icache_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     refill_done_i,
  input  logic     all_valid_i,
  input  way_idx_t inv_way_i,
  output way_oh_t  repl_way_oh_o
);

  logic [7:0] lfsr_q;
  logic       lfsr_fb;
  way_idx_t   repl_way;

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  // only step when a valid line was actually evicted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'hff;
    end else if (refill_done_i && all_valid_i) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
    end
  end

  assign repl_way = all_valid_i ? lfsr_q[WAY_IDX_W-1:0] : inv_way_i;

  // ways hold their read data between lookups
  // so this tracks the result of the last lookup until the refill
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      repl_way_oh_o <= '0;
    end else begin
      repl_way_oh_o <= way_oh_t'(1) << repl_way;
    end
  end

endmodule

// File: icache_ways.sv
// tag and line storage of all ways with tag compare, hit select and free way search
module icache_ways import icache_pkg::*; (
  input logic         clk_i,
  input logic         rst_ni,
  icache_array_if.arr arr_if
);

  tag_entry_t tag_rdata  [NUM_WAYS];
  line_t      line_rdata [NUM_WAYS];
  word_t      way_word   [NUM_WAYS];
  tag_entry_t tag_wdata;
  way_oh_t    way_vld;
  way_oh_t    way_hit;
  word_t      hit_word;
  way_idx_t   inv_idx;
  // lookup tag and offset, held for the compare in the next cycle
  tag_t       tag_q;
  offset_t    offset_q;

  // a clear writes an all zero entry, a refill a valid one
  assign tag_wdata = arr_if.vld_clr ? tag_entry_t'('0)
                                    : tag_entry_t'{valid: 1'b1, tag: arr_if.wr_tag};

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    logic tag_req;
    logic line_req;

    // clears hit every way, refills only the chosen one
    assign tag_req  = arr_if.rd_en | arr_if.vld_clr | (arr_if.wr_en & arr_if.wr_way_oh[w]);
    assign line_req = arr_if.rd_en | (arr_if.wr_en & arr_if.wr_way_oh[w]);

    icache_sram #(.payload_t(tag_entry_t)) i_tag_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (tag_req),
      .we_i    (arr_if.wr_en | arr_if.vld_clr),
      .addr_i  (arr_if.index),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[w])
    );

    icache_sram #(.payload_t(line_t)) i_line_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (line_req),
      .we_i    (arr_if.wr_en),
      .addr_i  (arr_if.index),
      .wdata_i (arr_if.wr_line),
      .rdata_o (line_rdata[w])
    );

    assign way_vld[w]  = tag_rdata[w].valid;
    assign way_hit[w]  = way_vld[w] & (tag_rdata[w].tag == tag_q);
    assign way_word[w] = line_rdata[w][{offset_q, 3'b000} +: FETCH_W];
  end

  always_ff @(posedge clk_i) begin
    if (arr_if.rd_en) begin
      tag_q    <= arr_if.wr_tag;
      offset_q <= arr_if.offset;
    end
  end

  // hit is one-hot, so an or over the masked words picks the hit way
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_hit[w]) begin
        hit_word = hit_word | way_word[w];
      end
    end
  end

  // lowest invalid way wins
  always_comb begin
    inv_idx = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!way_vld[w]) begin
        inv_idx = way_idx_t'(w);
      end
    end
  end

  assign arr_if.hit       = way_hit;
  assign arr_if.hit_data  = hit_word;
  assign arr_if.all_valid = &way_vld;
  assign arr_if.inv_way   = inv_idx;

endmodule

// File: icache_sram.sv
// synchronous single-port ram with registered read data and a typed payload
module icache_sram import icache_pkg::*; #(
  parameter type         payload_t = line_t,
  parameter int unsigned DEPTH     = NUM_SETS
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_i,
  input  logic     we_i,
  input  index_t   addr_i,
  input  payload_t wdata_i,
  output payload_t rdata_o
);

  payload_t mem_q [DEPTH];

  // entries clear at reset so that tag entries start out invalid
  // read data only changes on a read, writes leave it alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
      rdata_o <= '0;
    end else if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// File: icache_array_if.sv
// array request and lookup result bundle between cache controller and ways
interface icache_array_if import icache_pkg::*; ();

  // requests from the controller
  logic     rd_en;
  logic     wr_en;
  logic     vld_clr;
  index_t   index;
  way_oh_t  wr_way_oh;
  // tag of the lookup, and of the line being written on refill
  tag_t     wr_tag;
  line_t    wr_line;
  // word aligned byte offset of the lookup
  offset_t  offset;

  // lookup results, one cycle after rd_en
  way_oh_t  hit;
  word_t    hit_data;
  logic     all_valid;
  way_idx_t inv_way;

  modport ctrl (
    output rd_en, wr_en, vld_clr, index, wr_way_oh, wr_tag, wr_line, offset,
    input  hit, hit_data, all_valid, inv_way
  );

  modport arr (
    input  rd_en, wr_en, vld_clr, index, wr_way_oh, wr_tag, wr_line, offset,
    output hit, hit_data, all_valid, inv_way
  );

endinterface

// File: icache_pkg.sv
// instruction cache types and derived address field widths
package icache_pkg;

  `include "icache_params.svh"

  // geometry taken over from the macros
  localparam int unsigned NUM_WAYS   = `ICACHE_WAYS;
  localparam int unsigned NUM_SETS   = `ICACHE_SETS;
  localparam int unsigned LINE_BYTES = `ICACHE_LINE_BYTES;
  localparam int unsigned ADDR_W     = `ICACHE_ADDR_WIDTH;
  localparam int unsigned FETCH_W    = `ICACHE_FETCH_WIDTH;

  // address split is tag | index | offset
  localparam int unsigned INDEX_W    = $clog2(NUM_SETS);
  localparam int unsigned OFFSET_W   = $clog2(LINE_BYTES);
  localparam int unsigned TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
  localparam int unsigned LINE_W     = LINE_BYTES * 8;
  localparam int unsigned WAY_IDX_W  = $clog2(NUM_WAYS);

  typedef logic [INDEX_W-1:0]   index_t;
  typedef logic [OFFSET_W-1:0]  offset_t;
  typedef logic [TAG_W-1:0]     tag_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [FETCH_W-1:0]   word_t;
  typedef logic [LINE_W-1:0]    line_t;
  typedef logic [NUM_WAYS-1:0]  way_oh_t;
  typedef logic [WAY_IDX_W-1:0] way_idx_t;

  // tag ram payload, valid bit on top
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} state_e;

endpackage

// File: icache_params.svh
// instruction cache geometry and bus width macros
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

////////////////////
// cache geometry
////////////////////

// number of ways per set
`define ICACHE_WAYS 4
// number of sets, one line per way in each
`define ICACHE_SETS 16
// line size in bytes
`define ICACHE_LINE_BYTES 16

////////////////////
// bus widths
////////////////////

// physical fetch address
`define ICACHE_ADDR_WIDTH 32
// one instruction word
`define ICACHE_FETCH_WIDTH 32

`endif
